// ==== rtl/ddr_if_pkg.sv ====
package ddr_if_pkg;

   // ******************************************************************
   // DDR2 FIFO interface widths
   // ******************************************************************

   // address FIFO carries a 31-bit burst address
   localparam int ADDR_W = 31;

   // one write-data beat and its byte mask
   localparam int DATA_W = 128;
   localparam int MASK_W = DATA_W / 8;

   // ******************************************************************
   // address FIFO commands
   // ******************************************************************

   // encodings as the DDR2 controller expects them
   typedef enum logic [2:0] {
      CMD_WRITE = 3'b000,
      CMD_READ  = 3'b001
   } ddr_cmd_e;

   // mask sent on paths that never write data
   localparam logic [MASK_W-1:0] MASK_NONE = {MASK_W{1'b1}};

endpackage

// ==== rtl/arb_pkg.sv ====
package arb_pkg;

   // owner of the shared FIFOs in the current cycle
   typedef enum logic [2:0] {
      CL_NONE   = 3'd0,
      CL_ICACHE = 3'd1,
      CL_DCACHE = 3'd2,
      CL_PIXEL  = 3'd3,
      CL_LINE   = 3'd4
   } client_e;

   // read tags, wider than the FIFO depth so a wrapped tag never aliases
   // a read still in flight
   localparam int TAG_W = 11;

   // DDR2 returns two 128-bit beats per read burst
   localparam int BEATS_PER_READ = 2;

   // beat counter has one extra bit, tag = beats / BEATS_PER_READ
   localparam int BEAT_CNT_W = TAG_W + 1;

   // down-counter of beats still owed to a slot
   localparam int BEAT_LEFT_W = $clog2(BEATS_PER_READ + 1);

endpackage

// ==== rtl/req_arbiter.sv ====
`timescale 1ns/1ps

module req_arbiter (
   input  logic                          clk,
   input  logic                          rst,
   // DDR2 FIFO status
   input  logic                          i_af_full,
   input  logic                          i_wdf_full,
   // instruction cache
   input  logic                          i_ic_af_wr_en,
   input  ddr_if_pkg::ddr_cmd_e          i_ic_af_cmd,
   input  logic [ddr_if_pkg::ADDR_W-1:0] i_ic_addr,
   input  logic                          i_ic_wdf_wr_en,
   input  logic [ddr_if_pkg::DATA_W-1:0] i_ic_wdf_data,
   input  logic [ddr_if_pkg::MASK_W-1:0] i_ic_wdf_mask,
   // data cache
   input  logic                          i_dc_af_wr_en,
   input  ddr_if_pkg::ddr_cmd_e          i_dc_af_cmd,
   input  logic [ddr_if_pkg::ADDR_W-1:0] i_dc_addr,
   input  logic                          i_dc_wdf_wr_en,
   input  logic [ddr_if_pkg::DATA_W-1:0] i_dc_wdf_data,
   input  logic [ddr_if_pkg::MASK_W-1:0] i_dc_wdf_mask,
   // pixel feeder, reads only
   input  logic                          i_px_af_wr_en,
   input  logic [ddr_if_pkg::ADDR_W-1:0] i_px_addr,
   // line engine, writes only
   input  logic                          i_ln_af_wr_en,
   input  logic [ddr_if_pkg::ADDR_W-1:0] i_ln_addr,
   input  logic                          i_ln_wdf_wr_en,
   input  logic [ddr_if_pkg::DATA_W-1:0] i_ln_wdf_data,
   input  logic [ddr_if_pkg::MASK_W-1:0] i_ln_wdf_mask,
   // to the DDR2 FIFOs
   output logic                          o_af_wr_en,
   output ddr_if_pkg::ddr_cmd_e          o_af_cmd,
   output logic [ddr_if_pkg::ADDR_W-1:0] o_addr,
   output logic                          o_wdf_wr_en,
   output logic [ddr_if_pkg::DATA_W-1:0] o_wdf_data,
   output logic [ddr_if_pkg::MASK_W-1:0] o_wdf_mask,
   // per-client full flags
   output logic                          o_ic_af_full,
   output logic                          o_ic_wdf_full,
   output logic                          o_dc_af_full,
   output logic                          o_dc_wdf_full,
   output logic                          o_px_af_full,
   output logic                          o_ln_af_full,
   output logic                          o_ln_wdf_full,
   // to the read tracker
   output arb_pkg::client_e              o_grant,
   output logic                          o_read_issued
);

   import ddr_if_pkg::*;
   import arb_pkg::*;

   logic ic_req;
   logic dc_req;
   logic px_req;
   logic ln_req;
   logic busy;
   // set between the first and second beat of a line write
   logic line_rsv;

   assign ic_req = i_ic_af_wr_en || i_ic_wdf_wr_en;
   assign dc_req = i_dc_af_wr_en || i_dc_wdf_wr_en;
   assign px_req = i_px_af_wr_en;
   assign ln_req = i_ln_af_wr_en || i_ln_wdf_wr_en;

   // either FIFO full blocks both, so cmd and data go in together
   assign busy = i_af_full || i_wdf_full;

   // ******************************************************************
   // client selection
   // ******************************************************************

   always_comb begin
      o_grant = CL_NONE;
      if (line_rsv) begin
         // only the line engine may finish its pair of beats
         if (ln_req) begin
            o_grant = CL_LINE;
         end
      end else if (ic_req) begin
         o_grant = CL_ICACHE;
      end else if (dc_req) begin
         o_grant = CL_DCACHE;
      end else if (px_req) begin
         o_grant = CL_PIXEL;
      end else if (ln_req) begin
         o_grant = CL_LINE;
      end
   end

   // toggles on each accepted line beat
   always_ff @(posedge clk) begin
      if (rst) begin
         line_rsv <= 1'b0;
      end else if (o_grant == CL_LINE && !busy) begin
         line_rsv <= !line_rsv;
      end
   end

   // ******************************************************************
   // FIFO write mux
   // ******************************************************************

   always_comb begin
      // idle: icache values on the bus, nothing written
      o_af_cmd    = i_ic_af_cmd;
      o_addr      = i_ic_addr;
      o_wdf_data  = i_ic_wdf_data;
      o_wdf_mask  = i_ic_wdf_mask;
      o_af_wr_en  = 1'b0;
      o_wdf_wr_en = 1'b0;
      case (o_grant)
         CL_ICACHE: begin
            o_af_wr_en  = i_ic_af_wr_en && !busy;
            o_wdf_wr_en = i_ic_wdf_wr_en && !busy;
         end
         CL_DCACHE: begin
            o_af_cmd    = i_dc_af_cmd;
            o_addr      = i_dc_addr;
            o_wdf_data  = i_dc_wdf_data;
            o_wdf_mask  = i_dc_wdf_mask;
            o_af_wr_en  = i_dc_af_wr_en && !busy;
            o_wdf_wr_en = i_dc_wdf_wr_en && !busy;
         end
         CL_PIXEL: begin
            // read-only path, data FIFO untouched
            o_af_cmd    = CMD_READ;
            o_addr      = i_px_addr;
            o_wdf_data  = '0;
            o_wdf_mask  = MASK_NONE;
            o_af_wr_en  = i_px_af_wr_en && !busy;
         end
         CL_LINE: begin
            o_af_cmd    = CMD_WRITE;
            o_addr      = i_ln_addr;
            o_wdf_data  = i_ln_wdf_data;
            o_wdf_mask  = i_ln_wdf_mask;
            o_af_wr_en  = i_ln_af_wr_en && !busy;
            o_wdf_wr_en = i_ln_wdf_wr_en && !busy;
         end
         default: begin
         end
      endcase
   end

   // counted by the tracker as one read issued
   assign o_read_issued = o_af_wr_en && (o_af_cmd == CMD_READ);

   // unselected clients always see full and hold their request
   assign o_ic_af_full  = (o_grant != CL_ICACHE) || busy;
   assign o_ic_wdf_full = (o_grant != CL_ICACHE) || busy;
   assign o_dc_af_full  = (o_grant != CL_DCACHE) || busy;
   assign o_dc_wdf_full = (o_grant != CL_DCACHE) || busy;
   assign o_px_af_full  = (o_grant != CL_PIXEL) || busy;
   assign o_ln_af_full  = (o_grant != CL_LINE) || busy;
   assign o_ln_wdf_full = (o_grant != CL_LINE) || busy;

endmodule

// ==== rtl/read_tracker.sv ====
`timescale 1ns/1ps

module read_tracker (
   input  logic             clk,
   input  logic             rst,
   // from the arbiter
   input  arb_pkg::client_e i_grant,
   input  logic             i_read_issued,
   // DDR2 read-data FIFO
   input  logic             i_rdf_valid,
   output logic             o_rdf_rd_en,
   // readers
   input  logic             i_ic_rdf_rd_en,
   input  logic             i_dc_rdf_rd_en,
   input  logic             i_px_rdf_rd_en,
   output logic             o_ic_rdf_valid,
   output logic             o_dc_rdf_valid,
   output logic             o_px_rdf_valid
);

   import arb_pkg::*;

   // slot index 0 is the icache, 1 the dcache
   localparam int N_SLOT = 2;

   logic [TAG_W-1:0]       issued_cnt;
   logic [BEAT_CNT_W-1:0]  serviced_cnt;
   // tag of the read whose beats are now at the FIFO head
   logic [TAG_W-1:0]       head_tag;
   logic [TAG_W-1:0]       slot_tag  [N_SLOT];
   logic [BEAT_LEFT_W-1:0] slot_left [N_SLOT];
   logic [N_SLOT-1:0]      slot_issue;
   logic [N_SLOT-1:0]      slot_hit;

   assign head_tag = TAG_W'(serviced_cnt / BEATS_PER_READ);

   assign slot_issue[0] = i_read_issued && (i_grant == CL_ICACHE);
   assign slot_issue[1] = i_read_issued && (i_grant == CL_DCACHE);

   // ******************************************************************
   // issue and service counters
   // ******************************************************************

   // both wrap freely, tags stay unique while fewer reads are in flight
   // than the tag range
   always_ff @(posedge clk) begin
      if (rst) begin
         issued_cnt   <= '0;
         serviced_cnt <= '0;
      end else begin
         if (i_read_issued) begin
            issued_cnt <= issued_cnt + 1'b1;
         end
         if (i_rdf_valid) begin
            serviced_cnt <= serviced_cnt + 1'b1;
         end
      end
   end

   // ******************************************************************
   // outstanding-read slots, one per cache
   // ******************************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int k = 0; k < N_SLOT; k++) begin
            slot_tag[k]  <= '0;
            slot_left[k] <= '0;
         end
      end else begin
         for (int k = 0; k < N_SLOT; k++) begin
            if (slot_issue[k]) begin
               // remember which read number belongs to this cache
               slot_tag[k]  <= issued_cnt;
               slot_left[k] <= BEAT_LEFT_W'(BEATS_PER_READ);
            end else if (slot_hit[k] && i_rdf_valid) begin
               slot_left[k] <= slot_left[k] - 1'b1;
            end
         end
      end
   end

   always_comb begin
      for (int k = 0; k < N_SLOT; k++) begin
         slot_hit[k] = (slot_left[k] != '0) && (slot_tag[k] == head_tag);
      end
   end

   // ******************************************************************
   // steering
   // ******************************************************************

   // beats not claimed by a cache belong to the pixel feeder
   assign o_rdf_rd_en = slot_hit[0] ? i_ic_rdf_rd_en :
                        slot_hit[1] ? i_dc_rdf_rd_en :
                        i_px_rdf_rd_en;

   assign o_ic_rdf_valid = i_rdf_valid && slot_hit[0];
   assign o_dc_rdf_valid = i_rdf_valid && !slot_hit[0] && slot_hit[1];
   assign o_px_rdf_valid = i_rdf_valid && (slot_hit == '0);

endmodule

// ==== rtl/ddr_request_ctrl.sv ====
`timescale 1ns/1ps

module ddr_request_ctrl (
   input  logic                          clk,
   input  logic                          rst,
   // instruction cache
   input  logic                          i_ic_af_wr_en,
   input  ddr_if_pkg::ddr_cmd_e          i_ic_af_cmd,
   input  logic [ddr_if_pkg::ADDR_W-1:0] i_ic_addr,
   input  logic                          i_ic_wdf_wr_en,
   input  logic [ddr_if_pkg::DATA_W-1:0] i_ic_wdf_data,
   input  logic [ddr_if_pkg::MASK_W-1:0] i_ic_wdf_mask,
   input  logic                          i_ic_rdf_rd_en,
   output logic                          o_ic_af_full,
   output logic                          o_ic_wdf_full,
   output logic                          o_ic_rdf_valid,
   // data cache
   input  logic                          i_dc_af_wr_en,
   input  ddr_if_pkg::ddr_cmd_e          i_dc_af_cmd,
   input  logic [ddr_if_pkg::ADDR_W-1:0] i_dc_addr,
   input  logic                          i_dc_wdf_wr_en,
   input  logic [ddr_if_pkg::DATA_W-1:0] i_dc_wdf_data,
   input  logic [ddr_if_pkg::MASK_W-1:0] i_dc_wdf_mask,
   input  logic                          i_dc_rdf_rd_en,
   output logic                          o_dc_af_full,
   output logic                          o_dc_wdf_full,
   output logic                          o_dc_rdf_valid,
   // pixel feeder
   input  logic                          i_px_af_wr_en,
   input  logic [ddr_if_pkg::ADDR_W-1:0] i_px_addr,
   input  logic                          i_px_rdf_rd_en,
   output logic                          o_px_af_full,
   output logic                          o_px_rdf_valid,
   // line engine
   input  logic                          i_ln_af_wr_en,
   input  logic [ddr_if_pkg::ADDR_W-1:0] i_ln_addr,
   input  logic                          i_ln_wdf_wr_en,
   input  logic [ddr_if_pkg::DATA_W-1:0] i_ln_wdf_data,
   input  logic [ddr_if_pkg::MASK_W-1:0] i_ln_wdf_mask,
   output logic                          o_ln_af_full,
   output logic                          o_ln_wdf_full,
   // DDR2 FIFOs
   input  logic                          i_af_full,
   input  logic                          i_wdf_full,
   input  logic                          i_rdf_valid,
   output logic                          o_af_wr_en,
   output ddr_if_pkg::ddr_cmd_e          o_af_cmd,
   output logic [ddr_if_pkg::ADDR_W-1:0] o_addr,
   output logic                          o_wdf_wr_en,
   output logic [ddr_if_pkg::DATA_W-1:0] o_wdf_data,
   output logic [ddr_if_pkg::MASK_W-1:0] o_wdf_mask,
   output logic                          o_rdf_rd_en
);

   import arb_pkg::*;

   // arbiter tells the tracker who owned the FIFOs when a read went out
   client_e grant;
   logic    read_issued;

   req_arbiter u_arb (
      .clk            (clk),
      .rst            (rst),
      .i_af_full      (i_af_full),
      .i_wdf_full     (i_wdf_full),
      .i_ic_af_wr_en  (i_ic_af_wr_en),
      .i_ic_af_cmd    (i_ic_af_cmd),
      .i_ic_addr      (i_ic_addr),
      .i_ic_wdf_wr_en (i_ic_wdf_wr_en),
      .i_ic_wdf_data  (i_ic_wdf_data),
      .i_ic_wdf_mask  (i_ic_wdf_mask),
      .i_dc_af_wr_en  (i_dc_af_wr_en),
      .i_dc_af_cmd    (i_dc_af_cmd),
      .i_dc_addr      (i_dc_addr),
      .i_dc_wdf_wr_en (i_dc_wdf_wr_en),
      .i_dc_wdf_data  (i_dc_wdf_data),
      .i_dc_wdf_mask  (i_dc_wdf_mask),
      .i_px_af_wr_en  (i_px_af_wr_en),
      .i_px_addr      (i_px_addr),
      .i_ln_af_wr_en  (i_ln_af_wr_en),
      .i_ln_addr      (i_ln_addr),
      .i_ln_wdf_wr_en (i_ln_wdf_wr_en),
      .i_ln_wdf_data  (i_ln_wdf_data),
      .i_ln_wdf_mask  (i_ln_wdf_mask),
      .o_af_wr_en     (o_af_wr_en),
      .o_af_cmd       (o_af_cmd),
      .o_addr         (o_addr),
      .o_wdf_wr_en    (o_wdf_wr_en),
      .o_wdf_data     (o_wdf_data),
      .o_wdf_mask     (o_wdf_mask),
      .o_ic_af_full   (o_ic_af_full),
      .o_ic_wdf_full  (o_ic_wdf_full),
      .o_dc_af_full   (o_dc_af_full),
      .o_dc_wdf_full  (o_dc_wdf_full),
      .o_px_af_full   (o_px_af_full),
      .o_ln_af_full   (o_ln_af_full),
      .o_ln_wdf_full  (o_ln_wdf_full),
      .o_grant        (grant),
      .o_read_issued  (read_issued)
   );

   read_tracker u_trk (
      .clk            (clk),
      .rst            (rst),
      .i_grant        (grant),
      .i_read_issued  (read_issued),
      .i_rdf_valid    (i_rdf_valid),
      .o_rdf_rd_en    (o_rdf_rd_en),
      .i_ic_rdf_rd_en (i_ic_rdf_rd_en),
      .i_dc_rdf_rd_en (i_dc_rdf_rd_en),
      .i_px_rdf_rd_en (i_px_rdf_rd_en),
      .o_ic_rdf_valid (o_ic_rdf_valid),
      .o_dc_rdf_valid (o_dc_rdf_valid),
      .o_px_rdf_valid (o_px_rdf_valid)
   );

endmodule

// ==== include/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ******************************************************************
// expected arbitration
// ******************************************************************

// grant from the raw requests and the model's copy of the reservation
function automatic arb_pkg::client_e expected_grant(input logic ic_req, input logic dc_req,
                                                    input logic px_req, input logic ln_req,
                                                    input logic rsv);
   if (rsv) begin
      return ln_req ? arb_pkg::CL_LINE : arb_pkg::CL_NONE;
   end
   if (ic_req) return arb_pkg::CL_ICACHE;
   if (dc_req) return arb_pkg::CL_DCACHE;
   if (px_req) return arb_pkg::CL_PIXEL;
   if (ln_req) return arb_pkg::CL_LINE;
   return arb_pkg::CL_NONE;
endfunction

// ******************************************************************
// DDR2 read model
// ******************************************************************

// requester of every issued read in issue order
arb_pkg::client_e ref_rd_q[$];
// beats already returned for the read at the queue head
int unsigned      ref_beat_cnt;

task automatic record_read(input arb_pkg::client_e who);
   ref_rd_q.push_back(who);
endtask

// beat this cycle unless the random gap holds it back
task automatic return_step(input int unsigned gap_pct, output logic beat);
   beat = (ref_rd_q.size() != 0) && ($urandom_range(99) >= gap_pct);
endtask

// owner of the beat now leaving the FIFO or the pixel feeder when nothing is tagged
function automatic arb_pkg::client_e beat_owner();
   if (ref_rd_q.size() == 0) return arb_pkg::CL_PIXEL;
   return ref_rd_q[0];
endfunction

task automatic retire_beat();
   ref_beat_cnt++;
   if (ref_beat_cnt == arb_pkg::BEATS_PER_READ) begin
      ref_beat_cnt = 0;
      void'(ref_rd_q.pop_front());
   end
endtask

`endif

// ==== tests/tb_ddr_request_ctrl.sv ====
`timescale 1ns/1ps

module tb_ddr_request_ctrl;

   import ddr_if_pkg::*;
   import arb_pkg::*;

   // about 2500 cycles of stimulus plus margin for draining reads
   localparam int CYCLE_LIMIT = 4000;
   localparam int MIX_CYCLES  = 2000;

   logic                clk;
   logic                rst;
   logic                i_ic_af_wr_en;
   ddr_cmd_e            i_ic_af_cmd;
   logic [ADDR_W-1:0]   i_ic_addr;
   logic                i_ic_wdf_wr_en;
   logic [DATA_W-1:0]   i_ic_wdf_data;
   logic [MASK_W-1:0]   i_ic_wdf_mask;
   logic                i_ic_rdf_rd_en;
   logic                o_ic_af_full;
   logic                o_ic_wdf_full;
   logic                o_ic_rdf_valid;
   logic                i_dc_af_wr_en;
   ddr_cmd_e            i_dc_af_cmd;
   logic [ADDR_W-1:0]   i_dc_addr;
   logic                i_dc_wdf_wr_en;
   logic [DATA_W-1:0]   i_dc_wdf_data;
   logic [MASK_W-1:0]   i_dc_wdf_mask;
   logic                i_dc_rdf_rd_en;
   logic                o_dc_af_full;
   logic                o_dc_wdf_full;
   logic                o_dc_rdf_valid;
   logic                i_px_af_wr_en;
   logic [ADDR_W-1:0]   i_px_addr;
   logic                i_px_rdf_rd_en;
   logic                o_px_af_full;
   logic                o_px_rdf_valid;
   logic                i_ln_af_wr_en;
   logic [ADDR_W-1:0]   i_ln_addr;
   logic                i_ln_wdf_wr_en;
   logic [DATA_W-1:0]   i_ln_wdf_data;
   logic [MASK_W-1:0]   i_ln_wdf_mask;
   logic                o_ln_af_full;
   logic                o_ln_wdf_full;
   logic                i_af_full;
   logic                i_wdf_full;
   logic                i_rdf_valid;
   logic                o_af_wr_en;
   ddr_cmd_e            o_af_cmd;
   logic [ADDR_W-1:0]   o_addr;
   logic                o_wdf_wr_en;
   logic [DATA_W-1:0]   o_wdf_data;
   logic [MASK_W-1:0]   o_wdf_mask;
   logic                o_rdf_rd_en;

   // model copy of the line reservation
   logic                rsv_model;
   // per-client transfer in the cycle just checked
   logic                ic_took;
   logic                dc_took;
   logic                px_took;
   logic                ln_took;
   // expected values of the current cycle
   logic                busy;
   client_e             g;
   client_e             owner;
   logic                exp_af;
   logic                exp_wdf;
   ddr_cmd_e            exp_cmd;
   logic [ADDR_W-1:0]   exp_addr;
   logic [DATA_W-1:0]   exp_data;
   logic [MASK_W-1:0]   exp_mask;
   logic                exp_rd_en;
   logic                beat;
   logic                mix_on;
   int unsigned         gap_pct;
   int                  errors;
   int                  checked;
   int                  cycles;
   int                  ic_beats;
   int                  dc_beats;
   int                  px_beats;

   always #50 clk = !clk;

   ddr_request_ctrl DUT (.*);

   `include "tb_ref_model.svh"

   function automatic logic [DATA_W-1:0] random_beat();
      return {$urandom(), $urandom(), $urandom(), $urandom()};
   endfunction

   function automatic int reads_in_flight(input client_e who);
      int n;
      n = 0;
      foreach (ref_rd_q[k]) begin
         if (ref_rd_q[k] == who) n++;
      end
      return n;
   endfunction

   function automatic logic requests_pending();
      return i_ic_af_wr_en || i_ic_wdf_wr_en || i_dc_af_wr_en || i_dc_wdf_wr_en
             || i_px_af_wr_en || i_ln_af_wr_en || i_ln_wdf_wr_en;
   endfunction

   task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                  input logic [127:0] act_v);
      errors++;
      $display("MISMATCH %s at cycle %0d: expected %0h, got %0h", name, cycles, exp_v, act_v);
   endtask

   // ******************************************************************
   // client request drivers
   // ******************************************************************

   task automatic start_ic(input logic rd);
      i_ic_af_wr_en  <= 1'b1;
      i_ic_af_cmd    <= rd ? CMD_READ : CMD_WRITE;
      i_ic_addr      <= ADDR_W'($urandom());
      i_ic_wdf_wr_en <= !rd;
      i_ic_wdf_data  <= random_beat();
      i_ic_wdf_mask  <= MASK_W'($urandom());
   endtask

   task automatic start_dc(input logic rd);
      i_dc_af_wr_en  <= 1'b1;
      i_dc_af_cmd    <= rd ? CMD_READ : CMD_WRITE;
      i_dc_addr      <= ADDR_W'($urandom());
      i_dc_wdf_wr_en <= !rd;
      i_dc_wdf_data  <= random_beat();
      i_dc_wdf_mask  <= MASK_W'($urandom());
   endtask

   task automatic start_px();
      i_px_af_wr_en <= 1'b1;
      i_px_addr     <= ADDR_W'($urandom());
   endtask

   // first beat of a line write carries the command
   task automatic start_ln();
      i_ln_af_wr_en  <= 1'b1;
      i_ln_addr      <= ADDR_W'($urandom());
      i_ln_wdf_wr_en <= 1'b1;
      i_ln_wdf_data  <= random_beat();
      i_ln_wdf_mask  <= MASK_W'($urandom());
   endtask

   // one clock edge where taken requests drop and line beat 2 follows beat 1
   task automatic advance();
      @(posedge clk);
      if (ic_took) begin
         i_ic_af_wr_en  <= 1'b0;
         i_ic_wdf_wr_en <= 1'b0;
      end
      if (dc_took) begin
         i_dc_af_wr_en  <= 1'b0;
         i_dc_wdf_wr_en <= 1'b0;
      end
      if (px_took) i_px_af_wr_en <= 1'b0;
      if (ln_took && i_ln_af_wr_en) begin
         i_ln_af_wr_en <= 1'b0;
         i_ln_wdf_data <= random_beat();
      end else if (ln_took) begin
         i_ln_wdf_wr_en <= 1'b0;
      end
      if (mix_on) begin
         i_af_full  <= ($urandom_range(99) < 15);
         i_wdf_full <= ($urandom_range(99) < 15);
         // a cache reads only with no read of its own in flight
         if (!i_ic_af_wr_en && !i_ic_wdf_wr_en && $urandom_range(99) < 25) begin
            start_ic(($urandom_range(1) == 1) && reads_in_flight(CL_ICACHE) == 0);
         end
         if (!i_dc_af_wr_en && !i_dc_wdf_wr_en && $urandom_range(99) < 25) begin
            start_dc(($urandom_range(1) == 1) && reads_in_flight(CL_DCACHE) == 0);
         end
         if (!i_px_af_wr_en && $urandom_range(99) < 20) start_px();
         if (!i_ln_af_wr_en && !i_ln_wdf_wr_en && $urandom_range(99) < 20) start_ln();
      end
   endtask

   task automatic settle();
      advance();
      @(negedge clk);
      while (requests_pending()) begin
         advance();
         @(negedge clk);
      end
   endtask

   task automatic drain();
      while (ref_rd_q.size() != 0) advance();
   endtask

   // DDR2 read beats with random gaps and random rd_en pulses from the readers
   always @(posedge clk) begin
      if (rst) begin
         i_rdf_valid <= 1'b0;
      end else begin
         return_step(gap_pct, beat);
         i_rdf_valid    <= beat;
         i_ic_rdf_rd_en <= ($urandom_range(3) != 0);
         i_dc_rdf_rd_en <= ($urandom_range(3) != 0);
         i_px_rdf_rd_en <= ($urandom_range(3) != 0);
      end
   end

   // ******************************************************************
   // comparison at mid-cycle while inputs are stable
   // ******************************************************************

   always @(negedge clk) begin
      if (rst) begin
         rsv_model = 1'b0;
         ic_took   = 1'b0;
         dc_took   = 1'b0;
         px_took   = 1'b0;
         ln_took   = 1'b0;
      end else begin
         checked++;
         busy = i_af_full || i_wdf_full;
         g = expected_grant(i_ic_af_wr_en || i_ic_wdf_wr_en, i_dc_af_wr_en || i_dc_wdf_wr_en,
                            i_px_af_wr_en, i_ln_af_wr_en || i_ln_wdf_wr_en, rsv_model);
         exp_af   = 1'b0;
         exp_wdf  = 1'b0;
         exp_cmd  = CMD_WRITE;
         exp_addr = '0;
         exp_data = '0;
         exp_mask = '0;
         case (g)
            CL_ICACHE: begin
               exp_af   = i_ic_af_wr_en;
               exp_wdf  = i_ic_wdf_wr_en;
               exp_cmd  = i_ic_af_cmd;
               exp_addr = i_ic_addr;
               exp_data = i_ic_wdf_data;
               exp_mask = i_ic_wdf_mask;
            end
            CL_DCACHE: begin
               exp_af   = i_dc_af_wr_en;
               exp_wdf  = i_dc_wdf_wr_en;
               exp_cmd  = i_dc_af_cmd;
               exp_addr = i_dc_addr;
               exp_data = i_dc_wdf_data;
               exp_mask = i_dc_wdf_mask;
            end
            CL_PIXEL: begin
               exp_af   = i_px_af_wr_en;
               exp_cmd  = CMD_READ;
               exp_addr = i_px_addr;
            end
            CL_LINE: begin
               exp_af   = i_ln_af_wr_en;
               exp_wdf  = i_ln_wdf_wr_en;
               exp_addr = i_ln_addr;
               exp_data = i_ln_wdf_data;
               exp_mask = i_ln_wdf_mask;
            end
            default: begin
            end
         endcase
         // command and data enter together and only with both FIFOs free
         exp_af  = exp_af && !busy;
         exp_wdf = exp_wdf && !busy;
         if (o_af_wr_en !== exp_af) report_mismatch("o_af_wr_en", 128'(exp_af), 128'(o_af_wr_en));
         if (o_wdf_wr_en !== exp_wdf) begin
            report_mismatch("o_wdf_wr_en", 128'(exp_wdf), 128'(o_wdf_wr_en));
         end
         if (exp_af && o_af_cmd !== exp_cmd) begin
            report_mismatch("o_af_cmd", 128'(exp_cmd), 128'(o_af_cmd));
         end
         if (exp_af && o_addr !== exp_addr) begin
            report_mismatch("o_addr", 128'(exp_addr), 128'(o_addr));
         end
         if (exp_wdf && o_wdf_data !== exp_data) begin
            report_mismatch("o_wdf_data", exp_data, o_wdf_data);
         end
         if (exp_wdf && o_wdf_mask !== exp_mask) begin
            report_mismatch("o_wdf_mask", 128'(exp_mask), 128'(o_wdf_mask));
         end
         // full flags are high unless selected and then follow the FIFO state
         if (o_ic_af_full !== (g != CL_ICACHE || busy)) begin
            report_mismatch("o_ic_af_full", 128'(g != CL_ICACHE || busy), 128'(o_ic_af_full));
         end
         if (o_ic_wdf_full !== (g != CL_ICACHE || busy)) begin
            report_mismatch("o_ic_wdf_full", 128'(g != CL_ICACHE || busy), 128'(o_ic_wdf_full));
         end
         if (o_dc_af_full !== (g != CL_DCACHE || busy)) begin
            report_mismatch("o_dc_af_full", 128'(g != CL_DCACHE || busy), 128'(o_dc_af_full));
         end
         if (o_dc_wdf_full !== (g != CL_DCACHE || busy)) begin
            report_mismatch("o_dc_wdf_full", 128'(g != CL_DCACHE || busy), 128'(o_dc_wdf_full));
         end
         if (o_px_af_full !== (g != CL_PIXEL || busy)) begin
            report_mismatch("o_px_af_full", 128'(g != CL_PIXEL || busy), 128'(o_px_af_full));
         end
         if (o_ln_af_full !== (g != CL_LINE || busy)) begin
            report_mismatch("o_ln_af_full", 128'(g != CL_LINE || busy), 128'(o_ln_af_full));
         end
         if (o_ln_wdf_full !== (g != CL_LINE || busy)) begin
            report_mismatch("o_ln_wdf_full", 128'(g != CL_LINE || busy), 128'(o_ln_wdf_full));
         end
         // read return goes to the owner of the oldest read
         owner = beat_owner();
         exp_rd_en = (owner == CL_ICACHE) ? i_ic_rdf_rd_en :
                     (owner == CL_DCACHE) ? i_dc_rdf_rd_en : i_px_rdf_rd_en;
         if (o_rdf_rd_en !== exp_rd_en) begin
            report_mismatch("o_rdf_rd_en", 128'(exp_rd_en), 128'(o_rdf_rd_en));
         end
         if (o_ic_rdf_valid !== (i_rdf_valid && owner == CL_ICACHE)) begin
            report_mismatch("o_ic_rdf_valid", 128'(i_rdf_valid && owner == CL_ICACHE),
                            128'(o_ic_rdf_valid));
         end
         if (o_dc_rdf_valid !== (i_rdf_valid && owner == CL_DCACHE)) begin
            report_mismatch("o_dc_rdf_valid", 128'(i_rdf_valid && owner == CL_DCACHE),
                            128'(o_dc_rdf_valid));
         end
         if (o_px_rdf_valid !== (i_rdf_valid && owner == CL_PIXEL)) begin
            report_mismatch("o_px_rdf_valid", 128'(i_rdf_valid && owner == CL_PIXEL),
                            128'(o_px_rdf_valid));
         end
         // beats that actually reached each reader
         if (o_ic_rdf_valid === 1'b1) ic_beats++;
         if (o_dc_rdf_valid === 1'b1) dc_beats++;
         if (o_px_rdf_valid === 1'b1) px_beats++;
         // model state as it stands after the coming edge
         ic_took = (g == CL_ICACHE) && !busy;
         dc_took = (g == CL_DCACHE) && !busy;
         px_took = (g == CL_PIXEL) && !busy;
         ln_took = (g == CL_LINE) && !busy;
         if (exp_af && exp_cmd == CMD_READ) record_read(g);
         if (ln_took) rsv_model = !rsv_model;
         if (i_rdf_valid) retire_beat();
      end
   end

   // ******************************************************************
   // test sequence
   // ******************************************************************

   initial begin
      void'($urandom(32'h69f8_9680));
      clk = 1'b0;
      rst = 1'b1;
      {i_ic_af_wr_en, i_ic_wdf_wr_en, i_ic_rdf_rd_en} = '0;
      {i_dc_af_wr_en, i_dc_wdf_wr_en, i_dc_rdf_rd_en} = '0;
      {i_px_af_wr_en, i_px_rdf_rd_en, i_ln_af_wr_en, i_ln_wdf_wr_en} = '0;
      i_ic_af_cmd = CMD_WRITE;
      i_dc_af_cmd = CMD_WRITE;
      {i_ic_addr, i_dc_addr, i_px_addr, i_ln_addr} = '0;
      {i_ic_wdf_data, i_dc_wdf_data, i_ln_wdf_data} = '0;
      {i_ic_wdf_mask, i_dc_wdf_mask, i_ln_wdf_mask} = '0;
      {i_af_full, i_wdf_full, i_rdf_valid} = '0;
      mix_on  = 1'b0;
      gap_pct = 50;
      repeat (16) @(posedge clk);
      rst <= 1'b0;

      // all four request at once and the grant walks down the priority order
      advance();
      start_ic(1'b1);
      start_dc(1'b0);
      start_px();
      start_ln();
      settle();

      // either FIFO full holds everyone off and a held icache read is not counted
      drain();
      advance();
      i_af_full <= 1'b1;
      start_ic(1'b1);
      start_dc(1'b0);
      repeat (4) advance();
      i_af_full  <= 1'b0;
      i_wdf_full <= 1'b1;
      repeat (4) advance();
      i_wdf_full <= 1'b0;
      settle();

      // icache arrives between the two line beats and has to wait
      advance();
      start_ln();
      advance();
      start_ic(1'b0);
      settle();

      // four reads queued up and then returned with gaps
      drain();
      gap_pct <= 100;
      advance();
      start_ic(1'b1);
      settle();
      advance();
      start_px();
      settle();
      advance();
      start_dc(1'b1);
      settle();
      advance();
      start_px();
      settle();
      gap_pct <= 30;
      drain();

      // random traffic
      gap_pct <= 40;
      mix_on = 1'b1;
      repeat (MIX_CYCLES) advance();
      mix_on = 1'b0;
      advance();
      i_af_full  <= 1'b0;
      i_wdf_full <= 1'b0;
      settle();
      drain();
      repeat (4) advance();

      if (ic_beats == 0 || dc_beats == 0 || px_beats == 0) begin
         errors++;
         $display("read data never reached one of the readers: ic %0d dc %0d px %0d beats",
                  ic_beats, dc_beats, px_beats);
      end
      $display("checked %0d cycles, %0d errors", checked, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   // run limit
   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles, %0d errors so far",
               CYCLE_LIMIT, errors);
      $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+include
rtl/ddr_if_pkg.sv
rtl/arb_pkg.sv
rtl/req_arbiter.sv
rtl/read_tracker.sv
rtl/ddr_request_ctrl.sv
tests/tb_ddr_request_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --timescale 1ns/1ps \
   -f build.f --top-module tb_ddr_request_ctrl -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
   echo "simulation passed"
   exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
